// ==== logic/pet_bus_pkg.sv ====
package pet_bus_pkg;

    // Bus widths
    localparam int DATA_WIDTH     = 8;
    localparam int CPU_ADDR_WIDTH = 16;
    localparam int RAM_ADDR_WIDTH = 17;  // Host may reach the upper 64k
    localparam int REG_ADDR_WIDTH = 2;

    // CPU memory map
    localparam logic [CPU_ADDR_WIDTH-1:0] VRAM_BASE  = 16'h8000;
    localparam logic [CPU_ADDR_WIDTH-1:0] VRAM_LIMIT = 16'h8FFF;
    localparam logic [CPU_ADDR_WIDTH-1:0] ROM_BASE   = 16'hB000;  // Read-only from here up

    // Control register indices
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CPU    = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_VIDEO  = 2'd2;

    typedef enum logic [1:0] {
        OP_RAM_READ,
        OP_RAM_WRITE,
        OP_REG_READ,
        OP_REG_WRITE
    } host_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_SLOT,
        ST_ACCESS,
        ST_RESPOND
    } access_state_e;

endpackage

// ==== logic/slot_timer.sv ====
module slot_timer #(
    parameter int SLOT_CYCLES = 16
) (
    input  logic sys_clock_i,
    input  logic sys_reset_ni,
    output logic cpu_be_o,
    output logic cpu_clock_o,
    output logic cpu_data_strobe_o,
    output logic host_slot_o
);
    localparam int PHASE_W = $clog2(SLOT_CYCLES);
    localparam logic [PHASE_W-1:0] LAST    = PHASE_W'(SLOT_CYCLES - 1);
    localparam logic [PHASE_W-1:0] HALF    = PHASE_W'(SLOT_CYCLES / 2);
    localparam logic [PHASE_W-1:0] QUARTER = PHASE_W'(SLOT_CYCLES / 4);

    logic [PHASE_W-1:0] phase;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            phase <= '0;
        end else if (phase == LAST) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // First half belongs to the 6502
    assign cpu_be_o          = phase < HALF;
    assign cpu_clock_o       = (phase >= QUARTER) && (phase < HALF);  // Phi2 high
    assign cpu_data_strobe_o = phase == HALF - 1'b1;                  // Last CPU-owned cycle
    assign host_slot_o       = phase == HALF;                         // Host half begins

    // The host slot opens right after the CPU has latched its data
    a_slot_after_cpu: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        host_slot_o |-> !cpu_be_o && $past(cpu_data_strobe_o));

endmodule

// ==== logic/req_fifo.sv ====
module req_fifo import pet_bus_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,
    input  logic                      push_i,
    input  host_op_e                  op_i,
    input  logic [RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]     data_i,
    input  logic                      pop_i,
    output logic                      head_valid_o,
    output host_op_e                  head_op_o,
    output logic [RAM_ADDR_WIDTH-1:0] head_addr_o,
    output logic [DATA_WIDTH-1:0]     head_data_o,
    output logic                      credit_o
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

    host_op_e                  op_mem   [FIFO_DEPTH];
    logic [RAM_ADDR_WIDTH-1:0] addr_mem [FIFO_DEPTH];
    logic [DATA_WIDTH-1:0]     data_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign head_valid_o = count != '0;
    assign do_pop       = pop_i && head_valid_o;
    assign credit_o     = do_pop;  // One credit back per popped entry

    assign head_op_o   = op_mem[rd_ptr];
    assign head_addr_o = addr_mem[rd_ptr];
    assign head_data_o = data_mem[rd_ptr];

    always_ff @(posedge sys_clock_i) begin
        if (push_i) begin
            op_mem[wr_ptr]   <= op_i;
            addr_mem[wr_ptr] <= addr_i;
            data_mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Host must never push without a credit in hand
    a_no_overflow: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        push_i |-> count != CNT_W'(FIFO_DEPTH));

endmodule

// ==== logic/host_access_fsm.sv ====
module host_access_fsm import pet_bus_pkg::*; (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,
    input  logic                      head_valid_i,
    input  host_op_e                  head_op_i,
    input  logic [RAM_ADDR_WIDTH-1:0] head_addr_i,
    input  logic [DATA_WIDTH-1:0]     head_data_i,
    input  logic                      host_slot_i,
    input  logic [DATA_WIDTH-1:0]     ram_rdata_i,
    input  logic [DATA_WIDTH-1:0]     reg_rdata_i,
    output logic                      pop_o,
    output logic [RAM_ADDR_WIDTH-1:0] dma_addr_o,
    output logic                      dma_oe_o,
    output logic                      dma_we_o,
    output logic [DATA_WIDTH-1:0]     dma_wdata_o,
    output logic                      reg_we_o,
    output logic [REG_ADDR_WIDTH-1:0] reg_addr_o,
    output logic [DATA_WIDTH-1:0]     reg_wdata_o,
    output logic                      rsp_valid_o,
    output logic [DATA_WIDTH-1:0]     rsp_data_o
);
    access_state_e         state;
    logic                  beat;     // Second RAM access cycle
    logic                  is_reg;
    logic                  done;     // Last cycle of ST_ACCESS
    logic [DATA_WIDTH-1:0] rd_byte;

    assign is_reg = (head_op_i == OP_REG_READ) || (head_op_i == OP_REG_WRITE);
    assign done   = (state == ST_ACCESS) && (is_reg || beat);

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state <= ST_IDLE;
            beat  <= 1'b0;
        end else begin
            beat <= (state == ST_ACCESS) && !beat && !is_reg;
            case (state)
                ST_IDLE: begin
                    if (head_valid_i) state <= is_reg ? ST_ACCESS : ST_WAIT_SLOT;
                end
                ST_WAIT_SLOT: begin
                    if (host_slot_i) state <= ST_ACCESS;  // Host half starts next cycle
                end
                ST_ACCESS: begin
                    if (done) state <= ST_RESPOND;
                end
                default: state <= ST_IDLE;  // ST_RESPOND
            endcase
        end
    end

    // Read byte is sampled at the end of the access, writes answer with 0
    always_ff @(posedge sys_clock_i) begin
        if (done) begin
            case (head_op_i)
                OP_RAM_READ: rd_byte <= ram_rdata_i;
                OP_REG_READ: rd_byte <= reg_rdata_i;
                default:     rd_byte <= '0;
            endcase
        end
    end

    // Head entry stays put until popped, so it drives the strobes directly
    assign dma_addr_o  = head_addr_i;
    assign dma_wdata_o = head_data_i;
    assign dma_oe_o    = (state == ST_ACCESS) && (head_op_i == OP_RAM_READ);
    assign dma_we_o    = (state == ST_ACCESS) && (head_op_i == OP_RAM_WRITE);

    assign reg_addr_o  = head_addr_i[REG_ADDR_WIDTH-1:0];
    assign reg_wdata_o = head_data_i;
    assign reg_we_o    = (state == ST_ACCESS) && (head_op_i == OP_REG_WRITE);

    assign rsp_valid_o = state == ST_RESPOND;
    assign pop_o       = state == ST_RESPOND;  // Credit returns with the response
    assign rsp_data_o  = rd_byte;

    // A RAM strobe is one kind only and lasts exactly two cycles
    a_dma_strobe: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        $rose(dma_oe_o || dma_we_o) |->
            !(dma_oe_o && dma_we_o) ##1 (dma_oe_o ^ dma_we_o) ##1 !(dma_oe_o || dma_we_o));

endmodule

// ==== logic/ram_port.sv ====
module ram_port import pet_bus_pkg::*; (
    input  logic                      sys_clock_i,
    input  logic                      cpu_be_i,
    input  logic                      cpu_clock_i,
    input  logic                      cpu_we_i,
    input  logic [CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [DATA_WIDTH-1:0]     cpu_data_i,
    input  logic [RAM_ADDR_WIDTH-1:0] dma_addr_i,
    input  logic                      dma_oe_i,
    input  logic                      dma_we_i,
    input  logic [DATA_WIDTH-1:0]     dma_wdata_i,
    input  logic [1:0]                vram_mask_i,
    input  logic                      col_80_i,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_data_oe_o
);
    logic                      is_vram;
    logic                      is_rom;
    logic                      a10_keep;
    logic                      a11_keep;
    logic [CPU_ADDR_WIDTH-1:0] cpu_addr_wrapped;

    assign is_vram = (cpu_addr_i >= VRAM_BASE) && (cpu_addr_i <= VRAM_LIMIT);
    assign is_rom  = cpu_addr_i >= ROM_BASE;

    // Video RAM wraps at 1k, 2k or 4k
    assign a10_keep = !is_vram || vram_mask_i[0] || col_80_i;  // 80 columns need 2k
    assign a11_keep = !is_vram || vram_mask_i[1];

    always_comb begin
        cpu_addr_wrapped     = cpu_addr_i;
        cpu_addr_wrapped[10] = cpu_addr_i[10] && a10_keep;
        cpu_addr_wrapped[11] = cpu_addr_i[11] && a11_keep;
    end

    always_comb begin
        if (cpu_be_i) begin
            ram_addr_o    = {1'b0, cpu_addr_wrapped};  // CPU sees the lower 64k only
            ram_oe_o      = !cpu_we_i;
            ram_we_o      = cpu_we_i && cpu_clock_i && !is_rom;
            ram_data_o    = cpu_data_i;
            ram_data_oe_o = 1'b0;                       // CPU drives the bus itself
        end else begin
            ram_addr_o    = dma_addr_i;
            ram_oe_o      = dma_oe_i;
            ram_we_o      = dma_we_i;
            ram_data_o    = dma_wdata_i;
            ram_data_oe_o = dma_we_i;
        end
    end

    // Host accesses must stay inside the host half of the slot
    a_host_in_slot: assert property (@(posedge sys_clock_i)
        cpu_be_i |-> !dma_oe_i && !dma_we_i);

endmodule

// ==== logic/control_regs.sv ====
module control_regs import pet_bus_pkg::*; (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,
    input  logic                      reg_we_i,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [DATA_WIDTH-1:0]     reg_wdata_i,
    input  logic                      config_crt_i,
    input  logic                      config_keyboard_i,
    output logic [DATA_WIDTH-1:0]     reg_rdata_o,
    output logic                      cpu_reset_o,
    output logic                      cpu_ready_o,
    output logic [1:0]                vram_mask_o,
    output logic                      col_80_o
);
    logic [1:0] cpu_q;    // [1] reset, [0] ready
    logic [1:0] mask_q;
    logic       col_80_q;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            cpu_q    <= 2'b10;  // CPU held in reset, not ready
            mask_q   <= 2'b00;
            col_80_q <= 1'b0;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                REG_CPU: cpu_q <= reg_wdata_i[1:0];
                REG_VIDEO: begin
                    col_80_q <= reg_wdata_i[0];
                    mask_q   <= reg_wdata_i[3:2];
                end
                default: ;  // Status is read-only
            endcase
        end
    end

    always_comb begin
        case (reg_addr_i)
            REG_STATUS: reg_rdata_o = {6'b0, config_keyboard_i, config_crt_i};
            REG_CPU:    reg_rdata_o = {6'b0, cpu_q};
            REG_VIDEO:  reg_rdata_o = {4'b0, mask_q, 1'b0, col_80_q};
            default:    reg_rdata_o = '0;
        endcase
    end

    assign cpu_ready_o = cpu_q[0];
    assign cpu_reset_o = cpu_q[1];
    assign vram_mask_o = mask_q;
    assign col_80_o    = col_80_q;

endmodule

// ==== logic/pet_bus_top.sv ====
module pet_bus_top import pet_bus_pkg::*; #(
    parameter int SLOT_CYCLES = 16,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                      sys_clock_i,
    input  logic                      sys_reset_ni,

    // Host request port
    input  logic                      host_valid_i,
    input  host_op_e                  host_op_i,
    input  logic [RAM_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [DATA_WIDTH-1:0]     host_data_i,
    output logic                      host_credit_o,
    output logic                      rsp_valid_o,
    output logic [DATA_WIDTH-1:0]     rsp_data_o,

    // 6502 pins
    input  logic [CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [DATA_WIDTH-1:0]     cpu_data_i,   // Shared board data bus
    input  logic                      cpu_we_i,
    output logic                      cpu_be_o,
    output logic                      cpu_clock_o,
    output logic                      cpu_data_strobe_o,
    output logic                      cpu_reset_o,
    output logic                      cpu_ready_o,

    // RAM pins
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_data_oe_o,

    input  logic                      config_crt_i,
    input  logic                      config_keyboard_i
);
    logic                      head_valid;
    host_op_e                  head_op;
    logic [RAM_ADDR_WIDTH-1:0] head_addr;
    logic [DATA_WIDTH-1:0]     head_data;
    logic                      pop;
    logic                      host_slot;
    logic [RAM_ADDR_WIDTH-1:0] dma_addr;
    logic                      dma_oe;
    logic                      dma_we;
    logic [DATA_WIDTH-1:0]     dma_wdata;
    logic                      reg_we;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [DATA_WIDTH-1:0]     reg_wdata;
    logic [DATA_WIDTH-1:0]     reg_rdata;
    logic [1:0]                vram_mask;
    logic                      col_80;

    slot_timer #(.SLOT_CYCLES(SLOT_CYCLES)) i_slot_timer (
        .sys_clock_i, .sys_reset_ni, .cpu_be_o, .cpu_clock_o, .cpu_data_strobe_o,
        .host_slot_o(host_slot)
    );

    req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_req_fifo (
        .sys_clock_i, .sys_reset_ni,
        .push_i(host_valid_i), .op_i(host_op_i), .addr_i(host_addr_i), .data_i(host_data_i),
        .pop_i(pop), .head_valid_o(head_valid), .head_op_o(head_op),
        .head_addr_o(head_addr), .head_data_o(head_data), .credit_o(host_credit_o)
    );

    host_access_fsm i_host_access_fsm (
        .sys_clock_i, .sys_reset_ni,
        .head_valid_i(head_valid), .head_op_i(head_op), .head_addr_i(head_addr),
        .head_data_i(head_data), .host_slot_i(host_slot),
        .ram_rdata_i(cpu_data_i),  // RAM answers on the shared bus
        .reg_rdata_i(reg_rdata), .pop_o(pop),
        .dma_addr_o(dma_addr), .dma_oe_o(dma_oe), .dma_we_o(dma_we), .dma_wdata_o(dma_wdata),
        .reg_we_o(reg_we), .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata),
        .rsp_valid_o, .rsp_data_o
    );

    ram_port i_ram_port (
        .sys_clock_i, .cpu_be_i(cpu_be_o), .cpu_clock_i(cpu_clock_o), .cpu_we_i, .cpu_addr_i,
        .cpu_data_i, .dma_addr_i(dma_addr), .dma_oe_i(dma_oe), .dma_we_i(dma_we),
        .dma_wdata_i(dma_wdata), .vram_mask_i(vram_mask), .col_80_i(col_80),
        .ram_addr_o, .ram_oe_o, .ram_we_o, .ram_data_o, .ram_data_oe_o
    );

    control_regs i_control_regs (
        .sys_clock_i, .sys_reset_ni,
        .reg_we_i(reg_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
        .config_crt_i, .config_keyboard_i, .reg_rdata_o(reg_rdata),
        .cpu_reset_o, .cpu_ready_o, .vram_mask_o(vram_mask), .col_80_o(col_80)
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clock_o,
    output logic reset_no
);
    initial begin
        clock_o = 1'b0;
        forever #(PERIOD / 2) clock_o = ~clock_o;
    end

    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_no = 1'b1;  // Released away from the active edge
    end

endmodule

// ==== bench/tb_top.sv ====
module tb_top import pet_bus_pkg::*; ();
    localparam int SLOT_CYCLES = 16;
    localparam int FIFO_DEPTH  = 4;
    localparam int HALF        = SLOT_CYCLES / 2;
    localparam int QUARTER     = SLOT_CYCLES / 4;
    localparam int TIMEOUT     = 20 * SLOT_CYCLES;  // Cycles allowed per wait
    localparam int RAM_BYTES   = 1 << RAM_ADDR_WIDTH;
    localparam logic [7:0] VIDEO_SETTINGS [6] = '{8'h00, 8'h01, 8'h04, 8'h08, 8'h0C, 8'h05};

    logic                      sys_clock;
    logic                      sys_reset_n;
    logic                      host_valid;
    host_op_e                  host_op;
    logic [RAM_ADDR_WIDTH-1:0] host_addr;
    logic [DATA_WIDTH-1:0]     host_data;
    logic                      host_credit;
    logic                      rsp_valid;
    logic [DATA_WIDTH-1:0]     rsp_data;
    logic [CPU_ADDR_WIDTH-1:0] cpu_addr;
    logic [DATA_WIDTH-1:0]     cpu_wdata;     // What the bench CPU puts on the bus
    logic [DATA_WIDTH-1:0]     cpu_data_bus;  // Shared board data bus
    logic                      cpu_we;
    logic                      cpu_be;
    logic                      cpu_clock;
    logic                      cpu_strobe;
    logic                      cpu_reset;
    logic                      cpu_ready;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                      ram_oe;
    logic                      ram_we;
    logic [DATA_WIDTH-1:0]     ram_data;
    logic                      ram_data_oe;
    logic                      config_crt;
    logic                      config_keyboard;

    logic [7:0]                ram [RAM_BYTES];
    logic [7:0]                shadow [int];  // Expected RAM contents
    logic [7:0]                exp_rsp [256];
    logic [7:0]                rsp_wr;
    logic [7:0]                rsp_rd;
    logic [7:0]                exp_head;
    int                        credits;
    int                        ref_phase;
    int                        strobe_gap;
    logic                      strobe_seen;
    logic                      pins_chk;
    logic [1:0]                exp_pins;
    logic [1:0]                cpu_pins;
    logic [2:0]                exp_window;
    logic [2:0]                dut_window;
    logic [1:0]                exp_strobes;
    logic [1:0]                dut_strobes;
    logic                      exp_data_oe;
    logic [RAM_ADDR_WIDTH-1:0] exp_cpu_addr;
    logic [1:0]                vid_mask;
    logic                      vid_col80;
    string                     test_name;
    int                        errors;
    int                        errors_base;
    int                        tests_run;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(3)) i_clock (
        .clock_o(sys_clock), .reset_no(sys_reset_n)
    );

    pet_bus_top #(.SLOT_CYCLES(SLOT_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .sys_clock_i(sys_clock), .sys_reset_ni(sys_reset_n),
        .host_valid_i(host_valid), .host_op_i(host_op), .host_addr_i(host_addr),
        .host_data_i(host_data), .host_credit_o(host_credit),
        .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data),
        .cpu_addr_i(cpu_addr), .cpu_data_i(cpu_data_bus), .cpu_we_i(cpu_we),
        .cpu_be_o(cpu_be), .cpu_clock_o(cpu_clock), .cpu_data_strobe_o(cpu_strobe),
        .cpu_reset_o(cpu_reset), .cpu_ready_o(cpu_ready),
        .ram_addr_o(ram_addr), .ram_oe_o(ram_oe), .ram_we_o(ram_we),
        .ram_data_o(ram_data), .ram_data_oe_o(ram_data_oe),
        .config_crt_i(config_crt), .config_keyboard_i(config_keyboard)
    );

    // 128k RAM, answers host reads on the shared bus
    always @(posedge sys_clock) begin
        if (ram_we) ram[ram_addr] <= ram_data;
    end
    assign cpu_data_bus = (!cpu_be && ram_oe) ? ram[ram_addr] : cpu_wdata;

    function automatic logic [15:0] wrap_vram(input logic [15:0] a, input logic [1:0] mask,
                                              input logic col80);
        logic [15:0] w;
        w = a;
        if (a >= VRAM_BASE && a <= VRAM_LIMIT) begin
            if (!(mask[0] || col80)) w[10] = 1'b0;
            if (!mask[1]) w[11] = 1'b0;
        end
        return w;
    endfunction

    // Reference phase, credit count and response pointer
    always_ff @(posedge sys_clock or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            credits     <= FIFO_DEPTH;
            ref_phase   <= 0;
            strobe_gap  <= 0;
            strobe_seen <= 1'b0;
            rsp_rd      <= '0;
        end else begin
            credits    <= credits - int'(host_valid) + int'(host_credit);
            ref_phase  <= (ref_phase == SLOT_CYCLES - 1) ? 0 : ref_phase + 1;
            strobe_gap <= cpu_strobe ? 1 : strobe_gap + 1;
            if (cpu_strobe) strobe_seen <= 1'b1;
            if (rsp_valid) rsp_rd <= rsp_rd + 1'b1;
        end
    end

    always_comb begin
        exp_head    = exp_rsp[rsp_rd];
        exp_window  = {ref_phase < HALF, ref_phase >= QUARTER && ref_phase < HALF,
                       ref_phase == HALF - 1};
        exp_strobes = {!cpu_we, cpu_we && exp_window[1] && cpu_addr < ROM_BASE};
        exp_data_oe = !exp_window[2] && ram_we;  // Host writes only
        exp_cpu_addr = {1'b0, wrap_vram(cpu_addr, vid_mask, vid_col80)};
    end

    assign cpu_pins    = {cpu_reset, cpu_ready};
    assign dut_window  = {cpu_be, cpu_clock, cpu_strobe};
    assign dut_strobes = {ram_oe, ram_we};

    a_rsp_expected: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        rsp_valid |-> rsp_rd != rsp_wr)
        else begin
            errors++;
            $display("ERROR %s: response arrived with no request pending", test_name);
        end

    a_rsp_data: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        rsp_valid |-> rsp_data == exp_head)
        else begin
            errors++;
            $display("MISMATCH %s: response expected %02h actual %02h", test_name,
                     $sampled(exp_head), $sampled(rsp_data));
        end

    a_cpu_pins: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        pins_chk |-> cpu_pins == exp_pins)
        else begin
            errors++;
            $display("MISMATCH %s: reset,ready expected %b actual %b", test_name,
                     $sampled(exp_pins), $sampled(cpu_pins));
        end

    a_strobe_period: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        cpu_strobe && strobe_seen |-> strobe_gap == SLOT_CYCLES)
        else begin
            errors++;
            $display("MISMATCH %s: strobe period expected %0d actual %0d", test_name,
                     SLOT_CYCLES, $sampled(strobe_gap));
        end

    // Bus enable, phi2 and strobe against the reference phase
    a_slot_window: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        dut_window == exp_window)
        else begin
            errors++;
            $display("MISMATCH %s: be,clock,strobe expected %b actual %b", test_name,
                     $sampled(exp_window), $sampled(dut_window));
        end

    // Only CPU strobes in the CPU half, never a write above ROM_BASE
    a_cpu_strobes: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        cpu_be |-> dut_strobes == exp_strobes)
        else begin
            errors++;
            $display("MISMATCH %s: oe,we in CPU half expected %b actual %b", test_name,
                     $sampled(exp_strobes), $sampled(dut_strobes));
        end

    a_cpu_write_addr: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        cpu_be && ram_we |-> ram_addr == exp_cpu_addr)
        else begin
            errors++;
            $display("MISMATCH %s: CPU write address expected %05h actual %05h", test_name,
                     $sampled(exp_cpu_addr), $sampled(ram_addr));
        end

    // DUT drives the data bus only while it writes in the host half
    a_data_drive: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        ram_data_oe == exp_data_oe)
        else begin
            errors++;
            $display("MISMATCH %s: data bus drive expected %b actual %b", test_name,
                     $sampled(exp_data_oe), $sampled(ram_data_oe));
        end

    a_credit_range: assert property (@(posedge sys_clock) disable iff (!sys_reset_n)
        credits >= 0 && credits <= FIFO_DEPTH)
        else begin
            errors++;
            $display("ERROR %s: host credit count left its range at %0d", test_name,
                     $sampled(credits));
        end

    task automatic stop_on_timeout(input string what);
        $display("ERROR %s: timed out waiting for %s", test_name, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic next_cycle_or_timeout(inout int waited, input string what);
        @(negedge sys_clock);
        waited++;
        if (waited > TIMEOUT) stop_on_timeout(what);
    endtask

    task automatic host_request(input host_op_e op, input logic [RAM_ADDR_WIDTH-1:0] addr,
                                input logic [7:0] data, input logic [7:0] expected);
        int waited;
        waited = 0;
        while (credits == 0) next_cycle_or_timeout(waited, "a host credit");
        host_valid       = 1'b1;
        host_op          = op;
        host_addr        = addr;
        host_data        = data;
        exp_rsp[rsp_wr]  = expected;  // Writes answer with 0
        rsp_wr           = rsp_wr + 1'b1;
        @(negedge sys_clock);
        host_valid = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (rsp_rd != rsp_wr) next_cycle_or_timeout(waited, "host responses");
    endtask

    task automatic wait_credits();
        int waited;
        waited = 0;
        while (credits != FIFO_DEPTH) next_cycle_or_timeout(waited, "all credits back");
    endtask

    task automatic wait_strobes(input int count);
        int waited;
        int seen;
        waited = 0;
        seen   = 0;
        while (seen < count) begin
            next_cycle_or_timeout(waited, "the CPU data strobe");
            if (cpu_strobe) seen++;
        end
    endtask

    // One CPU write, held from a host half through the next CPU half
    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        wait_strobes(1);
        @(negedge sys_clock);
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_we    = 1'b1;
        wait_strobes(1);
        @(negedge sys_clock);
        cpu_we    = 1'b0;
        cpu_addr  = '0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        errors_base = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("test %s finished with %0d failed checks", test_name, errors - errors_base);
    endtask

    task automatic check_reset_values();
        start_test("reset_values");
        exp_pins = 2'b10;
        pins_chk = 1'b1;
        repeat (4) @(negedge sys_clock);
        host_request(OP_REG_READ, RAM_ADDR_WIDTH'(REG_STATUS), 8'h00,
                     {6'b0, config_keyboard, config_crt});
        host_request(OP_REG_READ, RAM_ADDR_WIDTH'(REG_CPU), 8'h00, 8'h02);
        wait_responses();
        pins_chk = 1'b0;  // Pins change during the write
        host_request(OP_REG_WRITE, RAM_ADDR_WIDTH'(REG_CPU), 8'h01, 8'h00);
        wait_responses();
        exp_pins        = 2'b01;
        pins_chk        = 1'b1;
        config_crt      = 1'b0;
        config_keyboard = 1'b1;
        host_request(OP_REG_READ, RAM_ADDR_WIDTH'(REG_STATUS), 8'h00, 8'h02);
        host_request(OP_REG_READ, RAM_ADDR_WIDTH'(REG_CPU), 8'h00, 8'h01);
        wait_responses();
        finish_test();
    endtask

    task automatic check_credits();
        logic [RAM_ADDR_WIDTH-1:0] a;
        logic [7:0]                d;
        start_test("credits");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            a = RAM_ADDR_WIDTH'($urandom);
            d = 8'($urandom);
            shadow[int'(a)] = d;
            host_request(OP_RAM_WRITE, a, d, 8'h00);
        end
        wait_credits();
        wait_responses();
        finish_test();
    endtask

    task automatic check_host_round_trip();
        logic [RAM_ADDR_WIDTH-1:0] addrs [12];
        logic [7:0]                d;
        start_test("host_round_trip");
        for (int i = 0; i < 12; i++) begin
            addrs[i]     = RAM_ADDR_WIDTH'($urandom);
            addrs[i][16] = i[0];  // Half of them in the upper 64k
            d            = 8'($urandom);
            shadow[int'(addrs[i])] = d;
            host_request(OP_RAM_WRITE, addrs[i], d, 8'h00);
        end
        for (int i = 0; i < 12; i++) begin
            host_request(OP_RAM_READ, addrs[i], 8'h00, shadow[int'(addrs[i])]);
        end
        wait_responses();
        finish_test();
    endtask

    task automatic check_cpu_ram_path();
        logic [7:0]  s;
        logic [7:0]  d;
        logic [15:0] va;
        logic [15:0] wa;
        logic [15:0] ra;
        start_test("cpu_ram_path");
        foreach (VIDEO_SETTINGS[k]) begin
            s = VIDEO_SETTINGS[k];
            host_request(OP_REG_WRITE, RAM_ADDR_WIDTH'(REG_VIDEO), s, 8'h00);
            wait_responses();
            vid_col80 = s[0];
            vid_mask  = s[3:2];
            host_request(OP_REG_READ, RAM_ADDR_WIDTH'(REG_VIDEO), 8'h00, s & 8'h0D);
            wait_responses();

            va = VRAM_BASE + 16'($urandom % 4096);
            d  = 8'($urandom);
            wa = wrap_vram(va, vid_mask, vid_col80);
            cpu_write(va, d);
            shadow[int'(wa)] = d;
            host_request(OP_RAM_READ, {1'b0, wa}, 8'h00, d);

            // ROM byte must survive a CPU write
            ra = ROM_BASE + 16'($urandom % 32'h5000);
            shadow[int'(ra)] = ~d;
            host_request(OP_RAM_WRITE, {1'b0, ra}, ~d, 8'h00);
            wait_responses();
            cpu_write(ra, d);
            host_request(OP_RAM_READ, {1'b0, ra}, 8'h00, shadow[int'(ra)]);
            wait_responses();
        end
        finish_test();
    endtask

    initial begin
        int waited;
        void'($urandom(32'ha3b3_3abf));
        host_valid      = 1'b0;
        host_op         = OP_RAM_READ;
        host_addr       = '0;
        host_data       = '0;
        cpu_addr        = '0;
        cpu_wdata       = '0;
        cpu_we          = 1'b0;
        config_crt      = 1'b1;
        config_keyboard = 1'b0;
        rsp_wr          = '0;
        pins_chk        = 1'b0;
        exp_pins        = 2'b10;
        vid_mask        = 2'b00;
        vid_col80       = 1'b0;
        errors          = 0;
        errors_base     = 0;
        tests_run       = 0;
        test_name       = "startup";
        waited          = 0;
        while (!sys_reset_n) next_cycle_or_timeout(waited, "reset release");

        check_reset_values();
        start_test("slot_timing");
        wait_strobes(8);
        finish_test();
        check_credits();
        check_host_round_trip();
        check_cpu_ram_path();

        $display("tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/pet_bus_pkg.sv
logic/slot_timer.sv
logic/req_fifo.sv
logic/host_access_fsm.sv
logic/ram_port.sv
logic/control_regs.sv
logic/pet_bus_top.sv
bench/tb_clock.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
